//--- stb_mem_pkg.sv
// memory-side widths and LSU opcodes; widths are fixed here and are not module parameters
`default_nettype none

package stb_mem_pkg;

    // byte address toward the data cache
    localparam int ADDR_W = 32;

    // one data word per request
    localparam int DATA_W = 32;

    // one select bit per byte of a data word
    localparam int SEL_W = DATA_W / 8;

    // LSU request opcode
    // store encodes as 1, the same as a write enable
    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } lsu_op_e;

endpackage : stb_mem_pkg

`default_nettype wire

//--- stb_ctrl_pkg.sv
// FSM state encodings for the LSU-side and cache-side controllers; the code 2'b11 is unused
`default_nettype none

package stb_ctrl_pkg;

    // LSU-side controller
    // idle decodes a request, ack pulses for a store,
    // wait_load holds a load until the cache returns data
    typedef enum logic [1:0] {
        LSU_IDLE      = 2'b00,
        LSU_ACK       = 2'b01,
        LSU_WAIT_LOAD = 2'b10
    } lsu_state_e;

    // cache-side controller
    // drain writes the head entry, load forwards the LSU read
    typedef enum logic [1:0] {
        C_IDLE  = 2'b00,
        C_DRAIN = 2'b01,
        C_LOAD  = 2'b10
    } cache_state_e;

endpackage : stb_ctrl_pkg

`default_nettype wire

//--- store_buffer_datapath.sv
// store FIFO of BLEN entries (BLEN >= 2); a write to a full FIFO or a pop of an empty one is ignored
`timescale 1ns/1ps
`default_nettype none

module store_buffer_datapath
    import stb_mem_pkg::*;
#(
    parameter int BLEN = 4
) (
    input  wire                 clk,
    input  wire                 rst_i,
    // push from the LSU-side controller
    input  wire                 stb_wr_en_i,
    // pop and output select from the cache-side controller
    input  wire                 stb_rd_en_i,
    input  wire                 rd_sel_i,
    // live LSU request fields
    input  wire  [ADDR_W-1:0]   lsu_addr_i,
    input  wire  [DATA_W-1:0]   lsu_wdata_i,
    input  wire  [SEL_W-1:0]    lsu_sel_byte_i,
    input  wire                 lsu_dmem_sel_i,
    // fields toward the data cache
    output logic [ADDR_W-1:0]   dc_addr_o,
    output logic [DATA_W-1:0]   dc_wdata_o,
    output logic [SEL_W-1:0]    dc_sel_byte_o,
    output logic                dc_dmem_sel_o,
    // occupancy flags
    output logic                stb_full_o,
    output logic                stb_empty_o
);

    localparam int PTR_W = $clog2(BLEN);
    localparam int CNT_W = $clog2(BLEN + 1);

    // entry storage
    logic [ADDR_W-1:0] addr_mem [BLEN];
    logic [DATA_W-1:0] data_mem [BLEN];
    logic [SEL_W-1:0]  sel_mem  [BLEN];
    logic              dsel_mem [BLEN];

    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              wr_fire;
    logic              rd_fire;

    // pointer step, wraps at BLEN so any depth works
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(BLEN - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign stb_full_o  = (count_q == CNT_W'(BLEN));
    assign stb_empty_o = (count_q == '0);

    // guard against overflow and underflow
    assign wr_fire = stb_wr_en_i && !stb_full_o;
    assign rd_fire = stb_rd_en_i && !stb_empty_o;

    // pointers and count
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (rd_fire) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            // push and pop together leave the count as is
            case ({wr_fire, rd_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // payload write at the tail
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            addr_mem[wr_ptr_q] <= lsu_addr_i;
            data_mem[wr_ptr_q] <= lsu_wdata_i;
            sel_mem[wr_ptr_q]  <= lsu_sel_byte_i;
            dsel_mem[wr_ptr_q] <= lsu_dmem_sel_i;
        end
    end

    // 0 presents the head entry, 1 bypasses the live LSU fields
    always_comb begin
        if (rd_sel_i) begin
            dc_addr_o     = lsu_addr_i;
            dc_wdata_o    = lsu_wdata_i;
            dc_sel_byte_o = lsu_sel_byte_i;
            dc_dmem_sel_o = lsu_dmem_sel_i;
        end else begin
            dc_addr_o     = addr_mem[rd_ptr_q];
            dc_wdata_o    = data_mem[rd_ptr_q];
            dc_sel_byte_o = sel_mem[rd_ptr_q];
            dc_dmem_sel_o = dsel_mem[rd_ptr_q];
        end
    end

endmodule : store_buffer_datapath

`default_nettype wire

//--- lsu_stb_controller.sv
// LSU-side FSM; the LSU must hold req and fields until ack, and a load is acked only once the FIFO is empty
`timescale 1ns/1ps
`default_nettype none

module lsu_stb_controller
    import stb_mem_pkg::*;
    import stb_ctrl_pkg::*;
(
    input  wire             clk,
    input  wire             rst_i,
    // LSU request
    input  wire             lsu_req_i,
    input  wire lsu_op_e    lsu_op_i,
    // FIFO flags
    input  wire             stb_full_i,
    input  wire             stb_empty_i,
    // cache acknowledge
    input  wire             dc_ack_i,
    // push into the FIFO
    output logic            stb_wr_en_o,
    // load waiting for the cache-side controller
    output logic            load_pending_o,
    // acknowledge toward the LSU
    output logic            lsu_ack_o
);

    lsu_state_e state_q;
    lsu_state_e state_d;
    logic       is_store;
    logic       is_load;
    logic       load_ack;

    // request decode
    assign is_store = lsu_req_i && (lsu_op_i == OP_STORE);
    assign is_load  = lsu_req_i && (lsu_op_i == OP_LOAD);

    assign load_pending_o = (state_q == LSU_WAIT_LOAD);

    // no pushes happen while a load waits, so an ack seen
    // with the FIFO empty can only belong to the load
    assign load_ack = load_pending_o && dc_ack_i && stb_empty_i;

    // store ack one cycle after the push, load ack with the cache ack
    assign lsu_ack_o = (state_q == LSU_ACK) || load_ack;

    always_comb begin
        state_d     = state_q;
        stb_wr_en_o = 1'b0;
        case (state_q)
            LSU_IDLE: begin
                // a full FIFO back-pressures the store
                if (is_store && !stb_full_i) begin
                    stb_wr_en_o = 1'b1;
                    state_d     = LSU_ACK;
                end else if (is_load) begin
                    state_d = LSU_WAIT_LOAD;
                end
            end
            LSU_ACK: begin
                // req is still high here, do not decode it again
                state_d = LSU_IDLE;
            end
            LSU_WAIT_LOAD: begin
                if (load_ack) begin
                    state_d = LSU_IDLE;
                end
            end
            default: begin
                state_d = LSU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= LSU_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule : lsu_stb_controller

`default_nettype wire

//--- stb_cache_controller.sv
// cache-side FSM; one request per handshake, drain before load, and req drops for a cycle after each ack
`timescale 1ns/1ps
`default_nettype none

module stb_cache_controller
    import stb_mem_pkg::*;
    import stb_ctrl_pkg::*;
(
    input  wire     clk,
    input  wire     rst_i,
    // FIFO flag
    input  wire     stb_empty_i,
    // load held by the LSU-side controller
    input  wire     load_pending_i,
    // cache acknowledge
    input  wire     dc_ack_i,
    // pop of the head entry
    output logic    stb_rd_en_o,
    // output mux select, 1 for the LSU load fields
    output logic    rd_sel_o,
    // request toward the data cache
    output logic    dc_req_o,
    output logic    dc_w_en_o
);

    cache_state_e state_q;
    cache_state_e state_d;
    // operation on the cache port
    lsu_op_e      dc_op;

    always_comb begin
        state_d     = state_q;
        stb_rd_en_o = 1'b0;
        rd_sel_o    = 1'b0;
        dc_op       = OP_LOAD;
        case (state_q)
            C_IDLE: begin
                // queued stores go first, a load only sees an empty FIFO
                if (!stb_empty_i) begin
                    state_d = C_DRAIN;
                end else if (load_pending_i) begin
                    state_d = C_LOAD;
                end
            end
            C_DRAIN: begin
                dc_op = OP_STORE;
                // head leaves the FIFO at the ack edge
                if (dc_ack_i) begin
                    stb_rd_en_o = 1'b1;
                    state_d     = C_IDLE;
                end
            end
            C_LOAD: begin
                rd_sel_o = 1'b1;
                if (dc_ack_i) begin
                    state_d = C_IDLE;
                end
            end
            default: begin
                state_d = C_IDLE;
            end
        endcase
    end

    // request follows the state, so it rises the cycle after C_IDLE
    assign dc_req_o  = (state_q != C_IDLE);
    assign dc_w_en_o = (dc_op == OP_STORE);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= C_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule : stb_cache_controller

`default_nettype wire

//--- store_buffer_top.sv
// store buffer between LSU and data cache (BLEN >= 2); no forwarding, loads wait until all stores drain
`timescale 1ns/1ps
`default_nettype none

module store_buffer_top
    import stb_mem_pkg::*;
#(
    parameter int BLEN = 4
) (
    input  wire                 clk,
    input  wire                 rst_i,
    // LSU request
    input  wire                 lsu_req_i,
    input  wire lsu_op_e        lsu_op_i,
    input  wire  [ADDR_W-1:0]   lsu_addr_i,
    input  wire  [DATA_W-1:0]   lsu_wdata_i,
    input  wire  [SEL_W-1:0]    lsu_sel_byte_i,
    input  wire                 lsu_dmem_sel_i,
    // LSU response
    output logic                lsu_ack_o,
    output logic [DATA_W-1:0]   lsu_rdata_o,
    // data cache request
    output logic                dc_req_o,
    output logic                dc_w_en_o,
    output logic [ADDR_W-1:0]   dc_addr_o,
    output logic [DATA_W-1:0]   dc_wdata_o,
    output logic [SEL_W-1:0]    dc_sel_byte_o,
    output logic                dc_dmem_sel_o,
    output logic                stb_empty_o,
    // data cache response
    input  wire                 dc_ack_i,
    input  wire  [DATA_W-1:0]   dc_rdata_i
);

    // controller to datapath
    logic stb_wr_en;
    logic stb_rd_en;
    logic rd_sel;
    // datapath flags
    logic stb_full;
    logic stb_empty;
    // LSU-side to cache-side
    logic load_pending;

    store_buffer_datapath #(
        .BLEN(BLEN)
    ) u_datapath (
        .clk            (clk),
        .rst_i          (rst_i),
        .stb_wr_en_i    (stb_wr_en),
        .stb_rd_en_i    (stb_rd_en),
        .rd_sel_i       (rd_sel),
        .lsu_addr_i     (lsu_addr_i),
        .lsu_wdata_i    (lsu_wdata_i),
        .lsu_sel_byte_i (lsu_sel_byte_i),
        .lsu_dmem_sel_i (lsu_dmem_sel_i),
        .dc_addr_o      (dc_addr_o),
        .dc_wdata_o     (dc_wdata_o),
        .dc_sel_byte_o  (dc_sel_byte_o),
        .dc_dmem_sel_o  (dc_dmem_sel_o),
        .stb_full_o     (stb_full),
        .stb_empty_o    (stb_empty)
    );

    lsu_stb_controller u_lsu_ctrl (
        .clk            (clk),
        .rst_i          (rst_i),
        .lsu_req_i      (lsu_req_i),
        .lsu_op_i       (lsu_op_i),
        .stb_full_i     (stb_full),
        .stb_empty_i    (stb_empty),
        .dc_ack_i       (dc_ack_i),
        .stb_wr_en_o    (stb_wr_en),
        .load_pending_o (load_pending),
        .lsu_ack_o      (lsu_ack_o)
    );

    stb_cache_controller u_cache_ctrl (
        .clk            (clk),
        .rst_i          (rst_i),
        .stb_empty_i    (stb_empty),
        .load_pending_i (load_pending),
        .dc_ack_i       (dc_ack_i),
        .stb_rd_en_o    (stb_rd_en),
        .rd_sel_o       (rd_sel),
        .dc_req_o       (dc_req_o),
        .dc_w_en_o      (dc_w_en_o)
    );

    // load data bypasses the FIFO
    assign lsu_rdata_o = dc_rdata_i;
    assign stb_empty_o = stb_empty;

endmodule : store_buffer_top

`default_nettype wire

//--- store_buffer_properties.sv
// handshake assertions for store_buffer_top, bound into it; needs a simulator with concurrent assertions
`timescale 1ns/1ps
`default_nettype none

module store_buffer_properties
    import stb_mem_pkg::*;
(
    input wire              clk,
    input wire              rst_i,
    input wire              lsu_req_i,
    input wire              lsu_ack_o,
    input wire              dc_req_o,
    input wire              dc_w_en_o,
    input wire [ADDR_W-1:0] dc_addr_o,
    input wire [DATA_W-1:0] dc_wdata_o,
    input wire [SEL_W-1:0]  dc_sel_byte_o,
    input wire              dc_dmem_sel_o,
    input wire              stb_empty_o,
    input wire              dc_ack_i
);

    // number of failed assertions, summed into the final verdict
    int fail_cnt = 0;

    // cache request and its fields hold until ack
    req_stable_a: assert property (@(posedge clk) disable iff (rst_i)
        dc_req_o && !dc_ack_i |=> dc_req_o &&
            $stable({dc_w_en_o, dc_addr_o, dc_wdata_o, dc_sel_byte_o, dc_dmem_sel_o}))
        else begin
            $error("dc request or its fields changed before dc_ack_i");
            fail_cnt++;
        end

    // LSU ack only answers a live request
    ack_needs_req_a: assert property (@(posedge clk) disable iff (rst_i)
        lsu_ack_o |-> lsu_req_i)
        else begin
            $error("lsu_ack_o high without lsu_req_i");
            fail_cnt++;
        end

    // a write always has an entry behind it
    no_write_empty_a: assert property (@(posedge clk) disable iff (rst_i)
        !(dc_w_en_o && stb_empty_o))
        else begin
            $error("dc_w_en_o high while the store FIFO is empty");
            fail_cnt++;
        end

    // cache port quiet right after reset
    req_low_after_reset_a: assert property (@(posedge clk) rst_i |=> !dc_req_o)
        else begin
            $error("dc_req_o high in the cycle after reset");
            fail_cnt++;
        end

endmodule : store_buffer_properties

`default_nettype wire

//--- tb_store_buffer.sv
// BLEN 4; the cache model decodes only addr[7:2] (64 words) and acks after 0 to 5 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_store_buffer
    import stb_mem_pkg::*;
#(
    parameter int BLEN = 4
);

    localparam int TIMEOUT = 200;

    logic              clk;
    logic              rst_i;
    logic              lsu_req_i;
    lsu_op_e           lsu_op_i;
    logic [ADDR_W-1:0] lsu_addr_i;
    logic [DATA_W-1:0] lsu_wdata_i;
    logic [SEL_W-1:0]  lsu_sel_byte_i;
    logic              lsu_dmem_sel_i;
    logic              lsu_ack_o;
    logic [DATA_W-1:0] lsu_rdata_o;
    logic              dc_req_o;
    logic              dc_w_en_o;
    logic              dc_dmem_sel_o;
    logic              stb_empty_o;
    logic              dc_ack_i;
    logic [ADDR_W-1:0] dc_addr_o;
    logic [DATA_W-1:0] dc_wdata_o;
    logic [DATA_W-1:0] dc_rdata_i;
    logic [SEL_W-1:0]  dc_sel_byte_o;
    // cache model memory and the shadow copy kept in LSU issue order
    logic [DATA_W-1:0] cache_mem [64];
    logic [DATA_W-1:0] shadow_mem [64];
    // acked stores still owed to the cache as {dmem_sel, sel, addr, data}
    logic [ADDR_W+DATA_W+SEL_W:0] exp_wr_q [$];
    logic [31:0]       stim_rng;
    logic [31:0]       delay_rng;
    logic              hold_ack;
    int                force_delay;
    int                errors;
    int                checks;
    int                cache_writes;
    int                load_acks;
    int                failed_tests;

    store_buffer_top #(.BLEN(BLEN)) dut0 (.*);

    bind store_buffer_top store_buffer_properties u_props (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // reset contents depend on the whole word index
    function automatic logic [DATA_W-1:0] fill_word(input int idx);
        return 32'h5a00_0000 ^ (idx * 32'h0001_0203);
    endfunction

    function automatic logic [DATA_W-1:0] byte_mask(input logic [SEL_W-1:0] sel);
        logic [DATA_W-1:0] m;
        for (int b = 0; b < SEL_W; b++)
            m[b*8 +: 8] = {8{sel[b]}};
        return m;
    endfunction

    function automatic void shadow_store(input logic [ADDR_W-1:0] addr,
                                         input logic [DATA_W-1:0] data,
                                         input logic [SEL_W-1:0] sel);
        shadow_mem[addr[7:2]] = (shadow_mem[addr[7:2]] & ~byte_mask(sel)) | (data & byte_mask(sel));
    endfunction

    // expected load word keeps the selected shadow bytes and zeroes the rest
    function automatic logic [DATA_W-1:0] ref_load(input logic [ADDR_W-1:0] addr,
                                                   input logic [SEL_W-1:0] sel);
        return shadow_mem[addr[7:2]] & byte_mask(sel);
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // behavioral data cache answering one request per ack pulse
    initial begin : cache_model
        int wait_n;
        int idx;
        dc_ack_i   = 1'b0;
        dc_rdata_i = '0;
        for (int i = 0; i < 64; i++)
            cache_mem[i] = fill_word(i);
        forever begin
            // a request seen mid-cycle is answered from the next rising edge on
            @(negedge clk);
            if (dc_req_o && !rst_i) begin
                @(posedge clk);
                delay_rng = xorshift32(delay_rng);
                wait_n = (force_delay >= 0) ? force_delay : int'(delay_rng % 32'd6);
                repeat (wait_n) @(posedge clk);
                // back-pressure test keeps the ack back
                wait_n = 0;
                while (hold_ack && wait_n < TIMEOUT) begin
                    @(posedge clk);
                    wait_n++;
                end
                if (wait_n >= TIMEOUT) begin
                    errors++;
                    $display("cache model held its ack past the timeout at %0t", $time);
                end
                #2;
                idx = int'(dc_addr_o[7:2]);
                if (dc_w_en_o) begin
                    cache_mem[idx] = (cache_mem[idx] & ~byte_mask(dc_sel_byte_o)) |
                                     (dc_wdata_o & byte_mask(dc_sel_byte_o));
                    cache_writes++;
                end
                dc_rdata_i = cache_mem[idx];
                dc_ack_i   = 1'b1;
                @(posedge clk);
                #2;
                dc_ack_i = 1'b0;
            end
        end
    end

    // checks every ack at the falling edge where both handshakes are stable
    always @(negedge clk) begin : compare_proc
        logic [ADDR_W+DATA_W+SEL_W:0] exp_entry;
        if (!rst_i && lsu_ack_o && lsu_op_i == OP_STORE) begin
            shadow_store(lsu_addr_i, lsu_wdata_i, lsu_sel_byte_i);
            exp_wr_q.push_back({lsu_dmem_sel_i, lsu_sel_byte_i, lsu_addr_i, lsu_wdata_i});
        end
        if (!rst_i && lsu_ack_o && lsu_op_i == OP_LOAD) begin
            checks++;
            load_acks++;
            if (!stb_empty_o) begin
                errors++;
                $display("load acknowledged at %0t while stores were still queued", $time);
            end
            // bypassed read carries the live LSU fields to the cache
            if ({dc_dmem_sel_o, dc_sel_byte_o, dc_addr_o} !=
                    {lsu_dmem_sel_i, lsu_sel_byte_i, lsu_addr_i}) begin
                errors++;
                $display("FAIL t=%0t dc_{dmem_sel,sel_byte,addr}_o got=%h exp=%h", $time,
                         {dc_dmem_sel_o, dc_sel_byte_o, dc_addr_o},
                         {lsu_dmem_sel_i, lsu_sel_byte_i, lsu_addr_i});
            end
            if ((lsu_rdata_o & byte_mask(lsu_sel_byte_i)) !=
                    ref_load(lsu_addr_i, lsu_sel_byte_i)) begin
                errors++;
                $display("FAIL t=%0t lsu_rdata_o got=%h exp=%h", $time,
                         lsu_rdata_o & byte_mask(lsu_sel_byte_i),
                         ref_load(lsu_addr_i, lsu_sel_byte_i));
            end
        end
        if (!rst_i && dc_ack_i && dc_w_en_o) begin
            checks++;
            if (exp_wr_q.size() == 0) begin
                errors++;
                $display("cache write at %0t with no acknowledged store left", $time);
            end else begin
                exp_entry = exp_wr_q.pop_front();
                if ({dc_dmem_sel_o, dc_sel_byte_o, dc_addr_o, dc_wdata_o} != exp_entry) begin
                    errors++;
                    $display("FAIL t=%0t dc_{dmem_sel,sel_byte,addr,wdata}_o got=%h exp=%h",
                             $time, {dc_dmem_sel_o, dc_sel_byte_o, dc_addr_o, dc_wdata_o},
                             exp_entry);
                end
            end
        end
    end

    // one LSU request held until ack
    // cycles counts the falling edges waited
    task automatic lsu_access(input lsu_op_e op, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input logic [SEL_W-1:0] sel,
                              input logic dsel, output int cycles);
        @(posedge clk);
        #2;
        lsu_req_i      = 1'b1;
        lsu_op_i       = op;
        lsu_addr_i     = addr;
        lsu_wdata_i    = data;
        lsu_sel_byte_i = sel;
        lsu_dmem_sel_i = dsel;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!lsu_ack_o && cycles < TIMEOUT);
        if (!lsu_ack_o) begin
            errors++;
            $display("timeout at %0t: no lsu_ack_o for %s to %h", $time, op.name(), addr);
        end
        @(posedge clk);
        #2;
        lsu_req_i = 1'b0;
    endtask

    // 16-word window so loads hit earlier stores
    task automatic random_access(input logic allow_load, output int cycles);
        logic [31:0] r;
        lsu_op_e op;
        stim_rng = xorshift32(stim_rng);
        r  = stim_rng;
        op = (allow_load && r[31]) ? OP_LOAD : OP_STORE;
        lsu_access(op, {24'h0, 2'b00, r[3:0], 2'b00}, xorshift32(r), r[11:8], r[12], cycles);
    endtask

    task automatic wait_empty();
        int n;
        n = 0;
        while (!(stb_empty_o && !dc_req_o) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            errors++;
            $display("timeout at %0t: store buffer did not drain", $time);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("test %-24s ok", name);
        end else begin
            failed_tests++;
            $display("test %-24s failed with %0d errors", name, errors - err0);
        end
    endtask

    initial begin : main
        int e0;
        int cyc;
        int cyc_bg;
        int writes0;
        int loads0;
        int n;
        rst_i          = 1'b1;
        lsu_req_i      = 1'b0;
        lsu_op_i       = OP_LOAD;
        lsu_addr_i     = '0;
        lsu_wdata_i    = '0;
        lsu_sel_byte_i = '0;
        lsu_dmem_sel_i = 1'b0;
        hold_ack       = 1'b0;
        force_delay    = -1;
        stim_rng       = 32'd31;
        delay_rng      = 32'd31;
        errors         = 0;
        checks         = 0;
        cache_writes   = 0;
        load_acks      = 0;
        failed_tests   = 0;
        for (int i = 0; i < 64; i++)
            shadow_mem[i] = fill_word(i);
        repeat (2) @(posedge clk);
        #2;
        rst_i = 1'b0;

        e0 = errors;
        @(negedge clk);
        checks++;
        if (!stb_empty_o || lsu_ack_o || dc_req_o) begin
            errors++;
            $display("FAIL t=%0t stb_empty_o/lsu_ack_o/dc_req_o got=%b%b%b exp=100", $time,
                     stb_empty_o, lsu_ack_o, dc_req_o);
        end
        report_test("reset state", e0);

        e0 = errors;
        writes0 = cache_writes;
        lsu_access(OP_STORE, 32'h0000_0010, 32'hcafe_f00d, 4'b1011, 1'b1, cyc);
        checks++;
        if (cyc != 2) begin
            errors++;
            $display("FAIL t=%0t lsu_ack_o delay got=%0d exp=2", $time, cyc);
        end
        wait_empty();
        if (cache_writes != writes0 + 1) begin
            errors++;
            $display("single store never reached the cache");
        end
        report_test("store accept and drain", e0);

        e0 = errors;
        repeat (40) random_access(1'b0, cyc);
        wait_empty();
        for (int i = 0; i < 64; i++) begin
            if (cache_mem[i] != shadow_mem[i]) begin
                errors++;
                $display("FAIL t=%0t cache_mem[%0d] got=%h exp=%h", $time, i, cache_mem[i],
                         shadow_mem[i]);
            end
        end
        if (exp_wr_q.size() != 0) begin
            errors++;
            $display("%0d acknowledged stores never reached the cache", exp_wr_q.size());
        end
        report_test("write ordering", e0);

        // first drain is held so the FIFO fills up
        e0 = errors;
        hold_ack = 1'b1;
        n = 0;
        repeat (BLEN) begin
            random_access(1'b0, cyc);
            n += (cyc == 2) ? 1 : 0;
        end
        if (n != BLEN) begin
            errors++;
            $display("FAIL t=%0t prompt store acks got=%0d exp=%0d", $time, n, BLEN);
        end
        writes0 = cache_writes;
        fork
            lsu_access(OP_STORE, 32'h0000_0040, 32'h1234_5678, 4'hf, 1'b0, cyc_bg);
        join_none
        repeat (10) begin
            @(negedge clk);
            if (lsu_ack_o) begin
                errors++;
                $display("store acknowledged at %0t while the buffer was full", $time);
            end
        end
        hold_ack = 1'b0;
        n = 0;
        while (!lsu_ack_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (cache_writes == writes0) begin
            errors++;
            $display("stalled store acknowledged at %0t before any cache ack", $time);
        end
        wait fork;
        wait_empty();
        report_test("back-pressure", e0);

        // slow cache keeps the stores queued ahead of the load
        e0 = errors;
        loads0 = load_acks;
        force_delay = 5;
        lsu_access(OP_STORE, 32'h0000_0020, 32'h1111_2222, 4'hf, 1'b0, cyc);
        lsu_access(OP_STORE, 32'h0000_0024, 32'h3333_4444, 4'hf, 1'b1, cyc);
        lsu_access(OP_STORE, 32'h0000_0020, 32'haabb_ccdd, 4'b0110, 1'b0, cyc);
        fork
            lsu_access(OP_LOAD, 32'h0000_0020, '0, 4'hf, 1'b0, cyc_bg);
        join_none
        @(negedge clk);
        if (stb_empty_o) begin
            errors++;
            $display("no stores were queued when the load was issued");
        end
        wait fork;
        force_delay = -1;
        if (load_acks != loads0 + 1) begin
            errors++;
            $display("load behind stores was not acknowledged");
        end
        report_test("load after stores", e0);

        e0 = errors;
        loads0 = load_acks;
        repeat (200) random_access(1'b1, cyc);
        wait_empty();
        if (load_acks == loads0) begin
            errors++;
            $display("random mix issued no loads");
        end
        report_test("random mix", e0);

        $display("tests: 6, failed: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 failed_tests, checks, errors, dut0.u_props.fail_cnt);
        if (errors == 0 && failed_tests == 0 && dut0.u_props.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_store_buffer

`default_nettype wire

//--- store_buffer.f
stb_mem_pkg.sv
stb_ctrl_pkg.sv
store_buffer_datapath.sv
lsu_stb_controller.sv
stb_cache_controller.sv
store_buffer_top.sv
store_buffer_properties.sv
tb_store_buffer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_store_buffer
FILELIST  ?= store_buffer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
